// ==== rtl/gba_mem_pkg.sv ====
// Shared types for the handheld console memory controller
// Bus widths, transfer sizes, region map and the request and graphics structs

`default_nettype none

package gba_mem_pkg;

    typedef logic [31:0] addr_t;      // Bus byte address
    typedef logic [31:0] data_t;      // Bus data word
    typedef logic [3:0]  byte_en_t;   // One enable per byte lane
    typedef logic [15:0] half_t;      // Register half word
    typedef logic [1:0]  mem_size_t;  // Transfer size code

    localparam mem_size_t SIZE_BYTE = 2'd0;
    localparam mem_size_t SIZE_HALF = 2'd1;
    localparam mem_size_t SIZE_WORD = 2'd2;

    // Region bases, region number lives in bits 31:24
    localparam addr_t WORK_BASE = 32'h0300_0000;
    localparam addr_t IO_BASE   = 32'h0400_0000;
    localparam addr_t PAL_BASE  = 32'h0500_0000;
    localparam addr_t OAM_BASE  = 32'h0700_0000;

    localparam addr_t PAL_OBJ_OFFSET = 32'h0000_0200;  // Object palette half

    // I/O word indexes
    localparam int KEY_IDX = 76;   // KEYINPUT, offset 0x130
    localparam int INT_IDX = 128;  // IE / IF / IACK, offset 0x200

    // Request seen by every peer memory
    typedef struct packed {
        addr_t    mem_addr;
        data_t    wdata;
        byte_en_t byte_en;
    } mem_req_t;

    // One-hot region decode of the latched address
    typedef struct packed {
        logic work;
        logic pal_bg;
        logic pal_obj;
        logic oam;
        logic io;
    } region_sel_t;

    typedef struct packed {
        addr_t pal_bg;
        addr_t pal_obj;
        addr_t oam;
    } gfx_addr_t;

    typedef struct packed {
        data_t pal_bg;
        data_t pal_obj;
        data_t oam;
    } gfx_data_t;

    // Replace the enabled byte lanes of a stored word
    function automatic data_t lane_merge(data_t old_word, data_t new_word, byte_en_t en);
        data_t merged;
        merged = old_word;
        for (int b = 0; b < 4; b++) begin
            if (en[b])
                merged[8*b +: 8] = new_word[8*b +: 8];
        end
        return merged;
    endfunction

endpackage

`default_nettype wire

// ==== rtl/bus_front.sv ====
// CPU/DMA bus front end
// Holds each accepted write back one cycle, raises a one-cycle pause after it
// and turns the delayed size and low address bits into byte-lane enables

`default_nettype none

module bus_front (
    input  logic                  clock,
    input  logic                  reset,
    input  gba_mem_pkg::addr_t     bus_addr,
    input  gba_mem_pkg::data_t     bus_wdata,
    input  gba_mem_pkg::mem_size_t bus_size,
    input  logic                  bus_write,
    output logic                  bus_pause,
    output gba_mem_pkg::mem_req_t  req,
    output gba_mem_pkg::addr_t     lat_addr
);

    gba_mem_pkg::mem_size_t size_lat;
    gba_mem_pkg::byte_en_t  lanes;
    logic                   write_acc;
    logic                   write_lat;

    // A held write is masked while paused, so the pause never repeats
    assign write_acc = bus_write & ~bus_pause;

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            lat_addr  <= '0;
            size_lat  <= gba_mem_pkg::SIZE_BYTE;
            write_lat <= 1'b0;
        end else begin
            lat_addr  <= bus_addr;
            size_lat  <= bus_size;
            write_lat <= write_acc;
        end
    end

    assign bus_pause = write_lat;  // Pause lasts the commit cycle only

    // Little-endian lane enables
    always_comb begin
        case (size_lat)
            gba_mem_pkg::SIZE_BYTE: lanes = gba_mem_pkg::byte_en_t'(1) << lat_addr[1:0];
            gba_mem_pkg::SIZE_HALF: lanes = lat_addr[1] ? 4'b1100 : 4'b0011;
            gba_mem_pkg::SIZE_WORD: lanes = 4'b1111;
            default:                lanes = 4'b0000;
        endcase
    end

    always_comb begin
        req.mem_addr = write_lat ? lat_addr : bus_addr;  // Delayed address while writing
        req.wdata    = bus_wdata;                         // Master holds data through pause
        req.byte_en  = write_lat ? lanes : '0;
    end

    property p_pause_single;
        @(posedge clock) disable iff (reset)
            bus_pause |=> !bus_pause;
    endproperty
    a_pause_single: assert property (p_pause_single)
        else $error("bus_pause held for two cycles");

    // Lanes only open in the cycle after an accepted write
    property p_byte_en_after_write;
        @(posedge clock) disable iff (reset)
            (req.byte_en != '0) |-> $past(bus_write && !bus_pause);
    endproperty
    a_byte_en_after_write: assert property (p_byte_en_after_write)
        else $error("byte_en raised without an accepted write");

endmodule

`default_nettype wire

// ==== rtl/video_ram.sv ====
// Dual-port video memory block
// Port A is the byte-writable bus port with a write-first read,
// port B a read-only port for the graphics engine

`default_nettype none

module video_ram #(
    parameter int DEPTH = 128
) (
    input  logic                  clock,
    input  gba_mem_pkg::mem_req_t req,
    input  logic                  sel,
    output gba_mem_pkg::data_t    rdata,
    input  gba_mem_pkg::addr_t    gfx_addr,
    output gba_mem_pkg::data_t    gfx_data
);

    localparam int AW = $clog2(DEPTH);

    gba_mem_pkg::data_t    mem [DEPTH];
    gba_mem_pkg::byte_en_t a_we;
    gba_mem_pkg::data_t    a_word;
    logic [AW-1:0]         a_idx;
    logic [AW-1:0]         b_idx;

    assign a_idx = req.mem_addr[AW+1:2];  // Word index
    assign b_idx = gfx_addr[AW+1:2];
    assign a_we  = sel ? req.byte_en : '0;

    // Merged word is both the stored value and the read result
    assign a_word = gba_mem_pkg::lane_merge(mem[a_idx], req.wdata, a_we);

    always_ff @(posedge clock) begin
        if (|a_we)
            mem[a_idx] <= a_word;
        rdata <= a_word;
    end

    // Graphics side
    always_ff @(posedge clock) begin
        gfx_data <= mem[b_idx];
    end

endmodule

`default_nettype wire

// ==== rtl/work_ram.sv ====
// Internal work RAM
// Single bus port with byte-lane writes and a write-first synchronous read

`default_nettype none

module work_ram #(
    parameter int WORK_WORDS = 8192
) (
    input  logic                  clock,
    input  gba_mem_pkg::mem_req_t req,
    input  logic                  sel,
    output gba_mem_pkg::data_t    rdata
);

    localparam int AW = $clog2(WORK_WORDS);

    gba_mem_pkg::data_t    ram [WORK_WORDS];
    gba_mem_pkg::byte_en_t we;
    gba_mem_pkg::data_t    next_word;
    logic [AW-1:0]         idx;

    assign idx = req.mem_addr[AW+1:2];  // Upper addresses mirror
    assign we  = sel ? req.byte_en : '0;

    assign next_word = gba_mem_pkg::lane_merge(ram[idx], req.wdata, we);

    always_ff @(posedge clock) begin
        if (we != '0)
            ram[idx] <= next_word;
        rdata <= next_word;  // New data visible on the same port
    end

endmodule

`default_nettype wire

// ==== rtl/video_mem.sv ====
// Palette and OAM memories
// Background palette, object palette and OAM, each with its own graphics port

`default_nettype none

module video_mem (
    input  logic                   clock,
    input  gba_mem_pkg::mem_req_t  req,
    input  logic                   pal_bg_sel,
    input  logic                   pal_obj_sel,
    input  logic                   oam_sel,
    output gba_mem_pkg::data_t     rdata,
    input  gba_mem_pkg::gfx_addr_t gfx_addr,
    output gba_mem_pkg::gfx_data_t gfx_data
);

    gba_mem_pkg::mem_req_t obj_req;
    gba_mem_pkg::data_t    bg_rdata;
    gba_mem_pkg::data_t    obj_rdata;
    gba_mem_pkg::data_t    oam_rdata;
    gba_mem_pkg::data_t    bg_gfx;
    gba_mem_pkg::data_t    obj_gfx;
    gba_mem_pkg::data_t    oam_gfx;

    // Object palette starts at 0x200 within the palette region
    always_comb begin
        obj_req          = req;
        obj_req.mem_addr = req.mem_addr - gba_mem_pkg::PAL_OBJ_OFFSET;
    end

    video_ram #(.DEPTH(128)) u_pal_bg (
        .clock    (clock),
        .req      (req),
        .sel      (pal_bg_sel),
        .rdata    (bg_rdata),
        .gfx_addr (gfx_addr.pal_bg),
        .gfx_data (bg_gfx)
    );

    video_ram #(.DEPTH(128)) u_pal_obj (
        .clock    (clock),
        .req      (obj_req),
        .sel      (pal_obj_sel),
        .rdata    (obj_rdata),
        .gfx_addr (gfx_addr.pal_obj),
        .gfx_data (obj_gfx)
    );

    video_ram #(.DEPTH(256)) u_oam (
        .clock    (clock),
        .req      (req),
        .sel      (oam_sel),
        .rdata    (oam_rdata),
        .gfx_addr (gfx_addr.oam),
        .gfx_data (oam_gfx)
    );

    assign gfx_data = '{pal_bg: bg_gfx, pal_obj: obj_gfx, oam: oam_gfx};

    // Selects come from the latched address, so they line up with the RAM output
    always_comb begin
        if (pal_bg_sel)
            rdata = bg_rdata;
        else if (pal_obj_sel)
            rdata = obj_rdata;
        else if (oam_sel)
            rdata = oam_rdata;
        else
            rdata = '0;
    end

endmodule

`default_nettype wire

// ==== rtl/io_regs.sv ====
// I/O register file
// Byte-writable words plus KEYINPUT and the IE / IF / IACK interrupt word

`default_nettype none

module io_regs #(
    parameter int IO_WORDS = 132
) (
    input  logic                  clock,
    input  logic                  reset,
    input  gba_mem_pkg::mem_req_t req,
    input  gba_mem_pkg::addr_t    lat_addr,
    input  logic                  sel,
    input  gba_mem_pkg::half_t    buttons,
    input  gba_mem_pkg::half_t    reg_if,
    output gba_mem_pkg::half_t    int_acks,
    output gba_mem_pkg::data_t    rdata
);

    localparam int IW = $clog2(IO_WORDS);

    gba_mem_pkg::data_t    regs [IO_WORDS];
    gba_mem_pkg::byte_en_t ro_lanes;
    gba_mem_pkg::byte_en_t lane_we;
    logic [1:0]            ack_we;
    logic [IW-1:0]         wr_idx;
    logic [IW-1:0]         rd_idx;

    assign wr_idx = req.mem_addr[IW+1:2];
    assign rd_idx = lat_addr[IW+1:2];

    // Lanes that read live inputs are not stored
    always_comb begin
        ro_lanes = '0;
        if (wr_idx == IW'(gba_mem_pkg::KEY_IDX))
            ro_lanes = 4'b0011;  // Buttons
        else if (wr_idx == IW'(gba_mem_pkg::INT_IDX))
            ro_lanes = 4'b1100;  // IF on read, IACK on write
    end

    assign lane_we = sel ? (req.byte_en & ~ro_lanes) : '0;
    assign ack_we  = (sel && wr_idx == IW'(gba_mem_pkg::INT_IDX)) ? req.byte_en[3:2] : 2'b00;

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            for (int i = 0; i < IO_WORDS; i++)
                regs[i] <= '0;
        end else if (lane_we != '0) begin
            regs[wr_idx] <= gba_mem_pkg::lane_merge(regs[wr_idx], req.wdata, lane_we);
        end
    end

    // Acknowledge pulse, unwritten lanes clear each cycle
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            int_acks <= '0;
        end else begin
            int_acks[15:8] <= ack_we[1] ? req.wdata[31:24] : 8'h00;
            int_acks[7:0]  <= ack_we[0] ? req.wdata[23:16] : 8'h00;
        end
    end

    // Combinational read from the latched address
    always_comb begin
        rdata = '0;
        if (rd_idx < IW'(IO_WORDS))
            rdata = regs[rd_idx];
        if (rd_idx == IW'(gba_mem_pkg::KEY_IDX))
            rdata[15:0] = buttons;
        if (rd_idx == IW'(gba_mem_pkg::INT_IDX))
            rdata[31:16] = reg_if;
    end

    // Write index stays inside the register file
    property p_io_in_range;
        @(posedge clock) disable iff (reset)
            (sel && req.byte_en != '0) |-> (req.mem_addr[23:2] < IO_WORDS);
    endproperty
    a_io_in_range: assert property (p_io_in_range)
        else $error("I/O write index outside the register file");

endmodule

`default_nettype wire

// ==== rtl/mem_top.sv ====
// Memory controller top level
// Decodes the latched bus address into regions, drives the peer memories
// from one shared request and returns the selected read word

`default_nettype none

module mem_top #(
    parameter int WORK_WORDS = 8192,
    parameter int IO_WORDS   = 132
) (
    input  logic                   clock,
    input  logic                   reset,
    input  gba_mem_pkg::addr_t     bus_addr,
    input  gba_mem_pkg::data_t     bus_wdata,
    input  gba_mem_pkg::mem_size_t bus_size,
    input  logic                   bus_write,
    output logic                   bus_pause,
    output gba_mem_pkg::data_t     bus_rdata,
    input  gba_mem_pkg::gfx_addr_t gfx_addr,
    output gba_mem_pkg::gfx_data_t gfx_data,
    input  gba_mem_pkg::half_t     buttons,
    input  gba_mem_pkg::half_t     reg_if,
    output gba_mem_pkg::half_t     int_acks
);

    gba_mem_pkg::mem_req_t    req;
    gba_mem_pkg::addr_t       lat_addr;
    gba_mem_pkg::region_sel_t rsel;
    gba_mem_pkg::data_t       work_rdata;
    gba_mem_pkg::data_t       video_rdata;
    gba_mem_pkg::data_t       io_rdata;
    logic [7:0]               region;
    logic [23:0]              offset;

    bus_front u_front (
        .clock, .reset, .bus_addr, .bus_wdata, .bus_size, .bus_write,
        .bus_pause, .req, .lat_addr
    );

    assign region = lat_addr[31:24];
    assign offset = lat_addr[23:0];

    always_comb begin
        rsel.work    = region == gba_mem_pkg::WORK_BASE[31:24];
        rsel.pal_bg  = region == gba_mem_pkg::PAL_BASE[31:24] &&
                       offset < gba_mem_pkg::PAL_OBJ_OFFSET[23:0];
        rsel.pal_obj = region == gba_mem_pkg::PAL_BASE[31:24] &&
                       offset >= gba_mem_pkg::PAL_OBJ_OFFSET[23:0] && offset <= 24'h3FF;
        rsel.oam     = region == gba_mem_pkg::OAM_BASE[31:24] && offset <= 24'h3FF;
        rsel.io      = region == gba_mem_pkg::IO_BASE[31:24] && offset[23:2] < IO_WORDS;
    end

    work_ram #(.WORK_WORDS(WORK_WORDS)) u_work (
        .clock, .req, .sel(rsel.work), .rdata(work_rdata)
    );

    video_mem u_video (
        .clock, .req,
        .pal_bg_sel  (rsel.pal_bg),
        .pal_obj_sel (rsel.pal_obj),
        .oam_sel     (rsel.oam),
        .rdata       (video_rdata),
        .gfx_addr, .gfx_data
    );

    io_regs #(.IO_WORDS(IO_WORDS)) u_io (
        .clock, .reset, .req, .lat_addr, .sel(rsel.io),
        .buttons, .reg_if, .int_acks, .rdata(io_rdata)
    );

    always_comb begin
        if (rsel.work)
            bus_rdata = work_rdata;
        else if (rsel.pal_bg || rsel.pal_obj || rsel.oam)
            bus_rdata = video_rdata;
        else if (rsel.io)
            bus_rdata = io_rdata;
        else
            bus_rdata = '0;  // Unmapped
    end

    property p_region_onehot;
        @(posedge clock) disable iff (reset)
            $onehot0(rsel);
    endproperty
    a_region_onehot: assert property (p_region_onehot)
        else $error("overlapping region decode");

endmodule

`default_nettype wire

// ==== sim/tb_ref_model.svh ====
// Reference model for the memory controller testbench
// Expected contents by word address, plus lane, region and read rules

`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

gba_mem_pkg::data_t ref_mem [gba_mem_pkg::addr_t];  // Word address to expected word

// Little-endian lanes from size and low address bits
function automatic gba_mem_pkg::byte_en_t ref_lanes(
    gba_mem_pkg::mem_size_t size, gba_mem_pkg::addr_t a
);
    case (size)
        gba_mem_pkg::SIZE_BYTE: return 4'b0001 << a[1:0];
        gba_mem_pkg::SIZE_HALF: return a[1] ? 4'b1100 : 4'b0011;
        gba_mem_pkg::SIZE_WORD: return 4'b1111;
        default:                return 4'b0000;
    endcase
endfunction

function automatic gba_mem_pkg::data_t ref_merge(
    gba_mem_pkg::data_t old_word, gba_mem_pkg::data_t new_word, gba_mem_pkg::byte_en_t lanes
);
    gba_mem_pkg::data_t mask;
    mask = {{8{lanes[3]}}, {8{lanes[2]}}, {8{lanes[1]}}, {8{lanes[0]}}};
    return (old_word & ~mask) | (new_word & mask);
endfunction

// 0 unmapped, 1 work, 2 pal_bg, 3 pal_obj, 4 oam, 5 io
function automatic int ref_region(gba_mem_pkg::addr_t a);
    case (a[31:24])
        gba_mem_pkg::WORK_BASE[31:24]: return 1;
        gba_mem_pkg::PAL_BASE[31:24]:  return (a[23:0] < 24'h200) ? 2 : (a[23:0] < 24'h400) ? 3 : 0;
        gba_mem_pkg::OAM_BASE[31:24]:  return (a[23:0] < 24'h400) ? 4 : 0;
        gba_mem_pkg::IO_BASE[31:24]:   return (a[23:2] < 132) ? 5 : 0;
        default:                       return 0;
    endcase
endfunction

function automatic gba_mem_pkg::data_t expected_read(
    gba_mem_pkg::addr_t a, gba_mem_pkg::half_t btn, gba_mem_pkg::half_t irq
);
    gba_mem_pkg::addr_t w;
    gba_mem_pkg::data_t d;
    w = {a[31:2], 2'b00};
    d = ref_mem.exists(w) ? ref_mem[w] : '0;  // I/O words reset to zero
    if (ref_region(a) == 0)
        d = '0;
    if (ref_region(a) == 5 && a[23:2] == gba_mem_pkg::KEY_IDX)
        d[15:0] = btn;
    if (ref_region(a) == 5 && a[23:2] == gba_mem_pkg::INT_IDX)
        d[31:16] = irq;
    return d;
endfunction

function automatic void model_store(
    gba_mem_pkg::addr_t a, gba_mem_pkg::data_t d, gba_mem_pkg::mem_size_t size
);
    gba_mem_pkg::addr_t    w;
    gba_mem_pkg::byte_en_t lanes;
    w = {a[31:2], 2'b00};
    lanes = ref_lanes(size, a);
    if (ref_region(a) == 0)
        return;
    // Buttons and IF are live inputs, IACK lanes only pulse
    if (ref_region(a) == 5 && a[23:2] == gba_mem_pkg::KEY_IDX)
        lanes[1:0] = 2'b00;
    if (ref_region(a) == 5 && a[23:2] == gba_mem_pkg::INT_IDX)
        lanes[3:2] = 2'b00;
    ref_mem[w] = ref_merge(ref_mem.exists(w) ? ref_mem[w] : '0, d, lanes);
endfunction

`endif

// ==== sim/tb_mem_top.sv ====
// Testbench for the memory controller top level
// Drives the CPU/DMA bus and graphics ports, compares reads with a reference model

`default_nettype none

module tb_mem_top;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_RANDOM    = 400;
    localparam int N_DIRECTED  = 300;  // Bound on directed operations
    localparam int WATCHDOG_NS = (N_RANDOM + N_DIRECTED) * 4 * 8 + 2000;

    logic                   clock = 1'b0;
    logic                   reset;
    gba_mem_pkg::addr_t     bus_addr;
    gba_mem_pkg::data_t     bus_wdata;
    gba_mem_pkg::mem_size_t bus_size;
    logic                   bus_write;
    logic                   bus_pause;
    gba_mem_pkg::data_t     bus_rdata;
    gba_mem_pkg::gfx_addr_t gfx_addr;
    gba_mem_pkg::gfx_data_t gfx_data;
    gba_mem_pkg::half_t     buttons;
    gba_mem_pkg::half_t     reg_if;
    gba_mem_pkg::half_t     int_acks;

    gba_mem_pkg::addr_t pool [30];  // Six words each in work, pal_bg, pal_obj, oam, io
    gba_mem_pkg::addr_t unmapped [6] = '{32'h0200_0010, 32'h0600_0020, 32'h0500_04F0,
                                         32'h0700_0800, 32'h0400_0300, 32'h0800_0000};
    string              chk_name_q [$];
    int                 chk_kind_q [$];
    gba_mem_pkg::data_t chk_exp_q [$];
    string              due_name;
    int                 due_kind;
    gba_mem_pkg::data_t due_exp;
    logic               due_valid = 1'b0;
    logic               exp_pause;
    string              test_name = "reset values";
    int                 err_count = 0;
    int                 check_count = 0;
    int                 test_errs = 0;

    `include "tb_ref_model.svh"

    mem_top #(.WORK_WORDS(8192), .IO_WORDS(132)) i_dut (
        .clock, .reset, .bus_addr, .bus_wdata, .bus_size, .bus_write, .bus_pause,
        .bus_rdata, .gfx_addr, .gfx_data, .buttons, .reg_if, .int_acks
    );

    always #4 clock = ~clock;

    task automatic drive_idle();
        @(posedge clock);
        bus_write <= 1'b0;
    endtask

    task automatic queue_check(string name, int kind, gba_mem_pkg::data_t exp);
        chk_name_q.push_back(name);
        chk_kind_q.push_back(kind);
        chk_exp_q.push_back(exp);
    endtask

    // Inputs stay put through the pause cycle, the held write is masked
    task automatic bus_store(gba_mem_pkg::addr_t a, gba_mem_pkg::data_t d,
                             gba_mem_pkg::mem_size_t size);
        @(posedge clock);
        bus_addr  <= a;
        bus_wdata <= d;
        bus_size  <= size;
        bus_write <= 1'b1;
        model_store(a, d, size);
        @(posedge clock);
    endtask

    task automatic bus_load(string name, gba_mem_pkg::addr_t a);
        @(posedge clock);
        bus_addr  <= a;
        bus_size  <= gba_mem_pkg::SIZE_WORD;
        bus_write <= 1'b0;
        queue_check(name, 0, expected_read(a, buttons, reg_if));
    endtask

    task automatic gfx_load(string name, int kind, gba_mem_pkg::addr_t a);
        @(posedge clock);
        bus_write <= 1'b0;
        case (kind)
            1:       gfx_addr.pal_bg  <= a & 32'h1FC;
            2:       gfx_addr.pal_obj <= a & 32'h1FC;  // Offset within the object palette
            default: gfx_addr.oam     <= a & 32'h3FC;
        endcase
        queue_check(name, kind, ref_mem[{a[31:2], 2'b00}]);
    endtask

    task automatic end_test(string next_name);
        repeat (3) drive_idle();  // Let pending checks drain
        $display("test %-22s %0d errors", test_name, err_count - test_errs);
        test_name = next_name;
        test_errs = err_count;
    endtask

    // Compare process, each check is due one cycle after it was issued
    always @(negedge clock) begin
        gba_mem_pkg::data_t actual;
        if (due_valid) begin
            case (due_kind)
                0:       actual = bus_rdata;
                1:       actual = gfx_data.pal_bg;
                2:       actual = gfx_data.pal_obj;
                3:       actual = gfx_data.oam;
                default: actual = {16'h0000, int_acks};
            endcase
            check_count++;
            if (actual !== due_exp) begin
                $display("[ERROR] %s (%s): expected %h, actual %h",
                         test_name, due_name, due_exp, actual);
                err_count++;
            end
            due_valid = 1'b0;
        end
        if (chk_name_q.size() > 0) begin
            due_name  = chk_name_q.pop_front();
            due_kind  = chk_kind_q.pop_front();
            due_exp   = chk_exp_q.pop_front();
            due_valid = 1'b1;
        end
    end

    // Pause follows each accepted write by one cycle
    always @(negedge clock) begin
        if (reset) begin
            exp_pause = 1'b0;
        end else begin
            check_count++;
            if (bus_pause !== exp_pause) begin
                $display("[ERROR] %s (bus_pause): expected %b, actual %b",
                         test_name, exp_pause, bus_pause);
                err_count++;
            end
            exp_pause = bus_write && !exp_pause;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        int unsigned            seed_ret;
        int unsigned            r;
        int unsigned            op;
        gba_mem_pkg::addr_t     a;
        gba_mem_pkg::mem_size_t sz;
        gba_mem_pkg::half_t     ack;
        gba_mem_pkg::addr_t     key_addr;
        gba_mem_pkg::addr_t     int_addr;

        seed_ret  = $urandom(32'hc41a1257);
        reset     = 1'b1;
        bus_addr  = '0;
        bus_wdata = '0;
        bus_size  = gba_mem_pkg::SIZE_WORD;
        bus_write = 1'b0;
        gfx_addr  = '0;
        buttons   = '0;
        reg_if    = '0;
        key_addr  = gba_mem_pkg::IO_BASE + gba_mem_pkg::KEY_IDX * 4;
        int_addr  = gba_mem_pkg::IO_BASE + gba_mem_pkg::INT_IDX * 4;
        for (int k = 0; k < 6; k++) begin
            pool[k]      = gba_mem_pkg::WORK_BASE + k * 32'h1000 + ($urandom % 256) * 4;
            pool[6 + k]  = gba_mem_pkg::PAL_BASE + k * 32'h50 + ($urandom % 20) * 4;
            pool[12 + k] = gba_mem_pkg::PAL_BASE + gba_mem_pkg::PAL_OBJ_OFFSET
                           + k * 32'h50 + ($urandom % 20) * 4;
            pool[18 + k] = gba_mem_pkg::OAM_BASE + k * 32'hA0 + ($urandom % 40) * 4;
            pool[24 + k] = gba_mem_pkg::IO_BASE + (k * 26 + 1) * 4;  // Plain I/O words only
        end
        repeat (2) @(posedge clock);
        reset <= 1'b0;

        for (int k = 24; k < 30; k++)
            bus_load("I/O word", pool[k]);
        queue_check("int_acks", 4, '0);
        end_test("word round trip");

        for (int k = 0; k < 30; k++)
            bus_store(pool[k], $urandom, gba_mem_pkg::SIZE_WORD);
        for (int k = 0; k < 30; k++)
            bus_load("word read", pool[k]);
        end_test("byte and halfword");

        for (int k = 0; k < 30; k++) begin
            bus_store(pool[k] | ($urandom % 4), $urandom, gba_mem_pkg::SIZE_BYTE);
            bus_load("byte store", pool[k]);
            bus_store(pool[k] | (($urandom % 2) * 2), $urandom, gba_mem_pkg::SIZE_HALF);
            bus_load("halfword store", pool[k]);
        end
        end_test("write pause");

        for (int k = 0; k < 30; k += 6) begin
            bus_store(pool[k + 1], $urandom, gba_mem_pkg::SIZE_WORD);
            bus_load("read after write", pool[k + 1]);
            bus_store(pool[k + 2], $urandom, gba_mem_pkg::SIZE_WORD);
            bus_store(pool[k + 2] + 2, $urandom, gba_mem_pkg::SIZE_HALF);
            bus_load("back-to-back writes", pool[k + 2]);
        end
        end_test("graphics ports");

        for (int k = 6; k < 24; k++)
            gfx_load("graphics read", k / 6, pool[k]);
        end_test("keypad and interrupts");

        @(posedge clock);
        buttons <= gba_mem_pkg::half_t'($urandom);
        reg_if  <= gba_mem_pkg::half_t'($urandom);
        ack = gba_mem_pkg::half_t'($urandom) | 16'h0001;
        bus_store(key_addr, $urandom, gba_mem_pkg::SIZE_WORD);
        bus_load("KEYINPUT", key_addr);
        bus_store(int_addr, $urandom, gba_mem_pkg::SIZE_HALF);
        bus_load("IE and IF", int_addr);
        bus_store(int_addr + 2, {ack, 16'h0000}, gba_mem_pkg::SIZE_HALF);
        queue_check("IACK pulse", 4, {16'h0000, ack});
        drive_idle();
        queue_check("IACK cleared", 4, '0);
        bus_load("IE after IACK", int_addr);
        end_test("random traffic");

        for (int n = 0; n < N_RANDOM; n++) begin
            r = $urandom % 7;
            if (r < 5)
                a = pool[r * 6 + $urandom % 6] | ($urandom % 4);
            else
                a = unmapped[$urandom % 6];
            op = $urandom % 6;
            if (op < 3) begin
                bus_load("random read", a);
            end else begin
                sz = gba_mem_pkg::mem_size_t'(op - 3);
                if (sz == gba_mem_pkg::SIZE_HALF)
                    a[0] = 1'b0;
                if (sz == gba_mem_pkg::SIZE_WORD)
                    a[1:0] = 2'b00;
                bus_store(a, $urandom, sz);
            end
        end
        end_test("done");

        $display("checks: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+sim
rtl/gba_mem_pkg.sv
rtl/bus_front.sv
rtl/video_ram.sv
rtl/work_ram.sv
rtl/video_mem.sv
rtl/io_regs.sv
rtl/mem_top.sv
sim/tb_mem_top.sv
